// ==== rtl/stepper_params.svh ====
// Sizing, reset defaults and API version of the stepper controller for inclusion in every RTL file
`ifndef STEPPER_PARAMS_SVH
`define STEPPER_PARAMS_SVH

// Axes and datapath widths
`define NUM_MOTORS 2
`define WORD_BITS 64
`define DDA_BITS 64
`define DURATION_BITS 32
`define POS_BITS 32

// Move storage
`define QUEUE_DEPTH 2

// Tick divider
`define DIVISOR_BITS 8
`define DEFAULT_DIVISOR 32

// API version returned lowest byte first as patch, minor, major and devel
`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd0
`define VERSION_PATCH 8'd3
`define VERSION_DEVEL 8'd0

`endif

// ==== rtl/stepper_pkg.sv ====
// Command codes and shared record types that the stepper controller RTL modules import
`default_nettype none

`include "stepper_params.svh"

package stepper_pkg;

  // Header codes in the top byte of the first word of a message
  typedef enum logic [7:0] {
    COORDINATED_STEP = 8'h01,
    MOTOR_ENABLE     = 8'h0a,
    MOTOR_BRAKE      = 8'h0b,
    CLK_DIVISOR      = 8'h20,
    API_VERSION      = 8'hfe
  } cmd_e;

  // One complete coordinated move as assembled by the parser
  typedef struct packed {
    logic [`NUM_MOTORS-1:0]                dir;       // 1 counts up
    logic [`DURATION_BITS-1:0]             duration;  // In DDA ticks
    logic [`NUM_MOTORS-1:0][`DDA_BITS-1:0] increment;
    logic [`NUM_MOTORS-1:0][`DDA_BITS-1:0] increment_increment;  // Signed
  } move_t;

  // Motor-facing outputs
  typedef struct packed {
    logic [`NUM_MOTORS-1:0] step;
    logic [`NUM_MOTORS-1:0] dir;
    logic [`NUM_MOTORS-1:0] enable;
    logic [`NUM_MOTORS-1:0] brake;
  } motor_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/tick_divider.sv ====
// Programmable down-counter that paces all DDAs with a single-cycle tick
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module tick_divider (
  input  wire                      CLK,
  input  wire                      resetn,
  input  wire [`DIVISOR_BITS-1:0]  divisor,
  output logic                     tick
);

  logic [`DIVISOR_BITS-1:0] count;

  // Period is divisor+1 cycles
  always_ff @(posedge CLK) begin
    if (resetn) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= divisor;  // New divisor takes effect on reload
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dda_axis.sv ====
// Per-axis DDA with a ramped rate that emits step pulses and tracks the step position
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module dda_axis (
  input  wire                       CLK,
  input  wire                       resetn,
  input  wire                       tick,
  input  wire                       loading_move,
  input  wire                       executing_move,
  input  wire  [`DDA_BITS-1:0]      increment,
  input  wire  [`DDA_BITS-1:0]      increment_increment,
  input  wire                       dir,
  output logic                      step,
  output logic signed [`POS_BITS-1:0] position
);

  logic [`DDA_BITS-1:0] acc;
  logic [`DDA_BITS-1:0] rate;  // Two's complement and ramped each tick
  logic [`DDA_BITS:0]   sum;   // Top bit is the carry

  assign sum = {1'b0, acc} + {1'b0, rate};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc      <= '0;
      rate     <= '0;
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        acc  <= '0;
        rate <= increment;
      end else if (tick && executing_move) begin
        acc  <= sum[`DDA_BITS-1:0];
        rate <= rate + increment_increment;
        step <= sum[`DDA_BITS];
        // Position tracks the pulse while dir still belongs to this move
        if (sum[`DDA_BITS])
          position <= dir ? position + 1'b1 : position - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/move_queue.sv ====
// Two-slot move store with the FSM that starts, times and retires moves on DDA ticks
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module move_queue
  import stepper_pkg::*;
(
  input  wire        CLK,
  input  wire        resetn,
  input  wire        tick,
  input  wire        halt,
  input  wire        push,
  input  wire move_t move,
  output logic       buffer_dtr,
  output logic       loading_move,
  output logic       executing_move,
  output move_t      active_move,
  output logic       move_done
);

  localparam int IDX_BITS = $clog2(`QUEUE_DEPTH);
  localparam int CNT_BITS = $clog2(`QUEUE_DEPTH + 1);

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e                    state;
  move_t                     slots [`QUEUE_DEPTH];
  logic [IDX_BITS-1:0]       wr_idx;
  logic [IDX_BITS-1:0]       rd_idx;
  logic [CNT_BITS-1:0]       fill;       // Includes the running move
  logic [`DURATION_BITS-1:0] remaining;  // Ticks left in the running move
  logic                      tick_en;
  logic                      last_tick;
  logic                      do_push;
  logic                      do_load;

  // A tick in the load cycle is skipped by the DDAs, so it is skipped here too
  assign tick_en        = tick & ~loading_move;
  assign last_tick      = (state == RUN) && tick_en && (remaining <= `DURATION_BITS'(1));
  assign executing_move = (state == RUN);
  assign buffer_dtr     = (fill < CNT_BITS'(`QUEUE_DEPTH));
  assign do_push        = push & buffer_dtr;  // Full queue drops the push
  assign do_load        = (state == IDLE) && tick && (fill != '0);
  assign move_done      = last_tick & ~halt;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state           <= IDLE;
      wr_idx          <= '0;
      rd_idx          <= '0;
      fill            <= '0;
      remaining       <= '0;
      loading_move    <= 1'b0;
      active_move.dir <= '0;
    end else if (halt) begin
      state        <= IDLE;
      rd_idx       <= wr_idx;
      fill         <= '0;
      loading_move <= 1'b0;
    end else begin
      loading_move <= do_load;
      if (do_push) begin
        slots[wr_idx] <= move;
        wr_idx <= (wr_idx == IDX_BITS'(`QUEUE_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
      end
      fill <= fill + CNT_BITS'(do_push) - CNT_BITS'(last_tick);

      if (do_load) begin
        state       <= RUN;
        remaining   <= slots[rd_idx].duration;
        active_move <= slots[rd_idx];
      end else if (last_tick) begin
        // Retire the slot and let the next move wait for the following tick
        state  <= IDLE;
        rd_idx <= (rd_idx == IDX_BITS'(`QUEUE_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
      end else if ((state == RUN) && tick_en) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/word_parser.sv ====
// Host word decoder that sets motor controls, assembles moves for the queue and returns readback
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module word_parser
  import stepper_pkg::*;
(
  input  wire                              CLK,
  input  wire                              resetn,
  input  wire        [`WORD_BITS-1:0]      word_data_received,
  input  wire                              word_received,
  output logic       [`WORD_BITS-1:0]      word_send_data,
  input  wire logic signed [`POS_BITS-1:0] position [`NUM_MOTORS],
  output logic                             push,
  output move_t                            move,
  output logic       [`NUM_MOTORS-1:0]     enable,
  output logic       [`NUM_MOTORS-1:0]     brake,
  output logic       [`DIVISOR_BITS-1:0]   divisor
);

  logic              word_received_q;
  logic              word_rise;
  logic [7:0]        message_header;
  logic [7:0]        word_count;
  logic              in_move;
  cmd_e              header_cmd;
  logic signed [`POS_BITS-1:0] pos_snap [`NUM_MOTORS];  // Positions at the move header

  assign word_rise  = word_received & ~word_received_q;
  assign in_move    = (message_header == COORDINATED_STEP);
  assign header_cmd = cmd_e'(word_data_received[`WORD_BITS-1 -: 8]);

  // Snapshot and move payload
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!in_move) begin
        if (header_cmd == COORDINATED_STEP) begin
          move.dir <= word_data_received[`NUM_MOTORS-1:0];
          for (int n = 0; n < `NUM_MOTORS; n++) begin
            pos_snap[n] <= position[n];
          end
        end
      end else begin
        if (word_count == 8'd1)
          move.duration <= word_data_received[`DURATION_BITS-1:0];
        for (int n = 0; n < `NUM_MOTORS; n++) begin
          if (word_count == 8'(2 * n + 2))
            move.increment[n] <= word_data_received[`DDA_BITS-1:0];
          if (word_count == 8'(2 * n + 3))
            move.increment_increment[n] <= word_data_received[`DDA_BITS-1:0];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      message_header  <= 8'd0;
      word_count      <= 8'd0;
      word_send_data  <= '0;
      push            <= 1'b0;
      enable          <= '0;
      brake           <= '0;
      divisor         <= `DIVISOR_BITS'(`DEFAULT_DIVISOR);
    end else begin
      word_received_q <= word_received;
      push            <= 1'b0;  // Single cycle
      if (word_rise) begin
        word_send_data <= '0;
        if (!in_move) begin
          message_header <= header_cmd;
          word_count     <= 8'd1;
          case (header_cmd)
            MOTOR_ENABLE: enable  <= word_data_received[`NUM_MOTORS-1:0];
            MOTOR_BRAKE:  brake   <= word_data_received[`NUM_MOTORS-1:0];
            CLK_DIVISOR:  divisor <= word_data_received[`DIVISOR_BITS-1:0];
            API_VERSION: begin
              word_send_data[31:0] <= {`VERSION_DEVEL, `VERSION_MAJOR,
                                       `VERSION_MINOR, `VERSION_PATCH};
            end
            default: ;  // Unknown headers are ignored
          endcase
        end else begin
          word_count <= word_count + 8'd1;
          if (word_count == 8'd1)
            word_send_data <= pos_snap[0];  // Sign extended
          for (int n = 0; n < `NUM_MOTORS; n++) begin
            // Increment word returns zero, already cleared above
            if (word_count == 8'(2 * n + 3)) begin
              if (n < `NUM_MOTORS - 1) begin
                word_send_data <= pos_snap[n+1];
              end else begin
                push           <= 1'b1;  // Move complete
                message_header <= 8'd0;
                word_count     <= 8'd0;
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/stepper_ctrl_top.sv ====
// Stepper controller top level joining the word parser, move queue, tick divider and axis DDAs
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module stepper_ctrl_top
  import stepper_pkg::*;
(
  input  wire                    CLK,
  input  wire                    resetn,
  input  wire [`WORD_BITS-1:0]   word_data_received,
  input  wire                    word_received,
  output logic [`WORD_BITS-1:0]  word_send_data,
  output logic                   buffer_dtr,
  output logic                   move_done,
  input  wire                    halt,
  output motor_ctrl_t            motor
);

  move_t                      push_move;
  move_t                      active_move;
  logic                       push;
  logic                       tick;
  logic                       loading_move;
  logic                       executing_move;
  logic [`NUM_MOTORS-1:0]     enable;
  logic [`NUM_MOTORS-1:0]     brake;
  logic [`NUM_MOTORS-1:0]     step;
  logic [`DIVISOR_BITS-1:0]   divisor;
  logic signed [`POS_BITS-1:0] position [`NUM_MOTORS];

  word_parser u_parser (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .position           (position),
    .push               (push),
    .move               (push_move),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor)
  );

  move_queue u_queue (
    .CLK            (CLK),
    .resetn         (resetn),
    .tick           (tick),
    .halt           (halt),
    .push           (push),
    .move           (push_move),
    .buffer_dtr     (buffer_dtr),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .active_move    (active_move),
    .move_done      (move_done)
  );

  tick_divider u_divider (
    .CLK     (CLK),
    .resetn  (resetn),
    .divisor (divisor),
    .tick    (tick)
  );

  for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_axis
    dda_axis u_axis (
      .CLK                 (CLK),
      .resetn              (resetn),
      .tick                (tick),
      .loading_move        (loading_move),
      .executing_move      (executing_move),
      .increment           (active_move.increment[i]),
      .increment_increment (active_move.increment_increment[i]),
      .dir                 (active_move.dir[i]),
      .step                (step[i]),
      .position            (position[i])
    );
  end

  // Dir follows the running move
  assign motor = '{step: step, dir: active_move.dir, enable: enable, brake: brake};

endmodule

`default_nettype wire

// ==== test/tb_stepper_ctrl.sv ====
// Self-checking testbench that drives host words into the stepper controller and checks steps and readback
`timescale 1ns/10ps
`default_nettype none

`include "stepper_params.svh"

module tb_stepper_ctrl
  import stepper_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 100000;

  // Expected outcome of one move
  typedef struct packed {
    logic [`NUM_MOTORS-1:0]       dir;
    logic [`NUM_MOTORS-1:0][31:0] steps;
  } expect_t;

  logic                  CLK;
  logic                  resetn;
  logic [`WORD_BITS-1:0] word_data_received;
  logic                  word_received;
  logic                  halt;
  logic [`WORD_BITS-1:0] word_send_data;
  logic                  buffer_dtr;
  logic                  move_done;
  motor_ctrl_t           motor;

  integer                      seed;
  int                          errors;
  int                          checks;
  int                          moves_sent;
  int                          moves_done;
  int                          check_delay;
  expect_t                     expect_q [$];
  string                       name_q [$];
  logic signed [`POS_BITS-1:0] exp_pos [`NUM_MOTORS];
  int unsigned                 step_count [`NUM_MOTORS];
  logic [`NUM_MOTORS-1:0]      done_dir;  // Direction seen on the last tick

  stepper_ctrl_top u_stepper_ctrl_top (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done),
    .halt               (halt),
    .motor              (motor)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // DDA rule with one accumulate per tick and the rate ramped afterwards
  function automatic int unsigned ref_steps(input logic [63:0] inc, input logic [63:0] incinc,
                                            input int unsigned duration);
    logic [64:0] sum;
    logic [63:0] acc;
    logic [63:0] rate;
    int unsigned n;
    acc  = '0;
    rate = inc;
    n    = 0;
    for (int unsigned t = 0; t < duration; t++) begin
      sum  = {1'b0, acc} + {1'b0, rate};
      n    = n + sum[64];  // Carry out is a step
      acc  = sum[63:0];
      rate = rate + incinc;
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (expected == actual) else begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_move();
    expect_t e;
    string   name;
    if (expect_q.size() == 0) begin
      $display("move_done pulsed while no move was outstanding");
      errors++;
    end else begin
      e    = expect_q.pop_front();
      name = name_q.pop_front();
      for (int i = 0; i < `NUM_MOTORS; i++)
        check_value($sformatf("%s axis %0d steps", name, i), 64'(e.steps[i]), 64'(step_count[i]));
      check_value($sformatf("%s dir", name), 64'(e.dir), 64'(done_dir));
    end
    for (int i = 0; i < `NUM_MOTORS; i++)
      step_count[i] = 0;
  endtask

  // Counts step pulses and compares once the last step of a move has landed
  always @(negedge CLK) begin
    if (resetn) begin
      check_delay = 0;
      for (int i = 0; i < `NUM_MOTORS; i++)
        step_count[i] = 0;
    end else begin
      for (int i = 0; i < `NUM_MOTORS; i++)
        if (motor.step[i]) step_count[i]++;
      if (check_delay != 0) begin
        check_delay--;
        if (check_delay == 0) compare_move();
      end
      if (move_done) begin
        done_dir    = motor.dir;
        check_delay = 2;  // Step trails the tick by one cycle
        moves_done++;
      end
    end
  end

  // Called and returns 1 ns after a rising edge
  task automatic send_word(input logic [`WORD_BITS-1:0] data);
    word_data_received = data;
    word_received      = 1'b1;
    repeat (3) @(posedge CLK);
    #1 word_received = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
  endtask

  task automatic wait_dtr();
    int n = 0;
    while (!buffer_dtr && n < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (!buffer_dtr) begin
      $display("Timed out waiting for a free queue slot");
      errors++;
    end
  endtask

  task automatic wait_move_done(output int cycles);
    cycles = 0;
    while (!move_done && cycles < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      cycles++;
    end
    if (!move_done) begin
      $display("Timed out waiting for move_done");
      errors++;
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic send_move(input string name, input logic [`NUM_MOTORS-1:0] dir,
                           input int unsigned duration,
                           input logic [`NUM_MOTORS-1:0][63:0] inc,
                           input logic [`NUM_MOTORS-1:0][63:0] incinc, input logic check_pos);
    expect_t e;
    e.dir = dir;
    for (int i = 0; i < `NUM_MOTORS; i++)
      e.steps[i] = ref_steps(inc[i], incinc[i], duration);
    send_word({COORDINATED_STEP, 56'(dir)});
    send_word(64'(duration));
    if (check_pos)
      check_value($sformatf("%s pos 0", name), 64'(exp_pos[0]), word_send_data);
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      send_word(inc[i]);
      check_value($sformatf("%s inc %0d readback", name, i), 64'd0, word_send_data);
      if (i == `NUM_MOTORS - 1) wait_dtr();  // Last word pushes
      send_word(incinc[i]);
      if (check_pos && i < `NUM_MOTORS - 1)
        check_value($sformatf("%s pos %0d", name, i + 1), 64'(exp_pos[i+1]), word_send_data);
    end
    expect_q.push_back(e);
    name_q.push_back(name);
    moves_sent++;
    for (int i = 0; i < `NUM_MOTORS; i++)
      exp_pos[i] = dir[i] ? exp_pos[i] + $signed(e.steps[i]) : exp_pos[i] - $signed(e.steps[i]);
  endtask

  initial begin
    logic [`NUM_MOTORS-1:0]       dir;
    int unsigned                  duration;
    logic [`NUM_MOTORS-1:0][63:0] inc;
    logic [`NUM_MOTORS-1:0][63:0] incinc;
    int                           cycles;
    int                           lo;
    int                           hi;
    seed               = 32'hd6273d43;
    errors             = 0;
    checks             = 0;
    moves_sent         = 0;
    moves_done         = 0;
    resetn             = 1'b1;
    word_data_received = '0;
    word_received      = 1'b0;
    halt               = 1'b0;
    for (int i = 0; i < `NUM_MOTORS; i++)
      exp_pos[i] = '0;
    repeat (10) @(posedge CLK);
    #1 resetn = 1'b0;
    repeat (2) @(posedge CLK);
    #1;

    // Reset state and version readback
    check_value("reset buffer_dtr", 64'd1, 64'(buffer_dtr));
    check_value("reset enable", 64'd0, 64'(motor.enable));
    check_value("reset brake", 64'd0, 64'(motor.brake));
    check_value("reset step", 64'd0, 64'(motor.step));
    send_word({API_VERSION, 56'd0});
    check_value("api version", {32'd0, `VERSION_DEVEL, `VERSION_MAJOR, `VERSION_MINOR,
                `VERSION_PATCH}, word_send_data);

    send_word({MOTOR_ENABLE, 56'h3});
    check_value("motor enable", 64'h3, 64'(motor.enable));
    send_word({MOTOR_BRAKE, 56'h2});
    check_value("motor brake", 64'h2, 64'(motor.brake));

    // Constant rate moves one at a time
    incinc = '0;
    for (int m = 0; m < 4; m++) begin
      dir      = `NUM_MOTORS'($random(seed));
      duration = 20 + ($unsigned($random(seed)) % 32);
      for (int i = 0; i < `NUM_MOTORS; i++)
        inc[i] = {$random(seed), $random(seed)} >> 1;  // Below half a step per tick
      send_move($sformatf("random move %0d", m), dir, duration, inc, incinc, 1'b1);
      wait_move_done(cycles);
    end

    // Ramp up on axis 0 and down on axis 1
    inc[0]    = 64'h1000_0000_0000_0000;
    incinc[0] = 64'h0080_0000_0000_0000;
    inc[1]    = 64'h4000_0000_0000_0000;
    incinc[1] = 64'hffc0_0000_0000_0000;
    send_move("accel move", 2'b01, 64, inc, incinc, 1'b1);
    wait_move_done(cycles);

    // Second move queued behind a long running one
    incinc = '0;
    for (int i = 0; i < `NUM_MOTORS; i++)
      inc[i] = {$random(seed), $random(seed)} >> 1;
    send_move("queued move a", 2'b10, 50, inc, incinc, 1'b1);
    for (int i = 0; i < `NUM_MOTORS; i++)
      inc[i] = {$random(seed), $random(seed)} >> 2;
    send_move("queued move b", 2'b01, 30, inc, incinc, 1'b0);
    check_value("buffer_dtr with queue full", 64'd0, 64'(buffer_dtr));
    wait_move_done(cycles);
    wait_move_done(cycles);

    // Faster ticks with the same step count
    send_word({CLK_DIVISOR, 56'd3});
    for (int i = 0; i < `NUM_MOTORS; i++)
      inc[i] = {$random(seed), $random(seed)} >> 1;
    send_move("divisor move", 2'b11, 40, inc, incinc, 1'b1);
    wait_move_done(cycles);
    lo = 40 * 4 - 6;
    hi = 42 * 4;
    checks++;
    assert (cycles >= lo && cycles <= hi) else begin
      $display("[FAIL] divisor tick rate: expected %0d to %0d cycles, actual %0d", lo, hi, cycles);
      errors++;
    end

    repeat (5) @(posedge CLK);
    check_value("move_done count", 64'(moves_sent), 64'(moves_done));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/stepper_pkg.sv
rtl/tick_divider.sv
rtl/dda_axis.sv
rtl/move_queue.sv
rtl/word_parser.sv
rtl/stepper_ctrl_top.sv
test/tb_stepper_ctrl.sv

// ==== Bender.yml ====
package:
  name: stepper_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/stepper_pkg.sv
      - rtl/tick_divider.sv
      - rtl/dda_axis.sv
      - rtl/move_queue.sv
      - rtl/word_parser.sv
      - rtl/stepper_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_stepper_ctrl.sv
